/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_axi_sram
FILELIST  ?= filelist.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the obj_dir build folder"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

/* design/axi_rd_channel.sv */
`timescale 1ns/1ps

module axi_rd_channel (
   input  logic                            aclk,
   input  logic                            arst_n,

   input  logic [axi_sram_pkg::addr_w-1:0] araddr,
   input  logic [1:0]                      arburst,
   input  logic [axi_sram_pkg::len_w-1:0]  arlen,
   input  logic [axi_sram_pkg::id_w-1:0]   arid,
   input  logic [2:0]                      arsize,
   input  logic                            arvalid,
   output logic                            arready,

   output logic [axi_sram_pkg::data_w-1:0] rdata,
   output logic [axi_sram_pkg::id_w-1:0]   rid,
   output logic [1:0]                      rresp,
   output logic                            rlast,
   output logic                            rvalid,
   input  logic                            rready,

   sram_if.rd                              sram
);

   logic                             busy;
   logic                             beat_valid;
   logic [axi_sram_pkg::index_w-1:0] cur_idx;
   logic [axi_sram_pkg::index_w-1:0] next_idx;
   logic [axi_sram_pkg::len_w-1:0]   beats_left;
   logic [axi_sram_pkg::id_w-1:0]    id_q;
   logic [1:0]                       burst_q;
   logic                             ar_fire;
   logic                             r_fire;
   logic                             last_fire;
   logic                             ren;

   assign ar_fire   = arvalid & arready;
   assign r_fire    = rvalid & rready;
   assign last_fire = r_fire & rlast;

   // one burst at a time
   assign arready = ~busy;

   // word asked from the sram this cycle
   always_comb begin
      if (ar_fire) begin
         next_idx = araddr[axi_sram_pkg::word_shift +: axi_sram_pkg::index_w];
      end else if (r_fire && burst_q != axi_sram_pkg::burst_fixed) begin
         // wrap is handled like incr, index wraps inside the bank
         next_idx = cur_idx + 1'b1;
      end else begin
         next_idx = cur_idx;
      end
   end

   // under back-pressure the same word is read again so rdata holds
   assign ren = ar_fire | (busy & ~last_fire);

   assign sram.raddr = next_idx;
   assign sram.ren   = ren;

   always_ff @(posedge aclk or negedge arst_n) begin
      if (!arst_n) begin
         busy       <= 1'b0;
         beat_valid <= 1'b0;
         beats_left <= '0;
      end else begin
         // data of a read issued last cycle is on rdata now
         beat_valid <= ren;
         if (ar_fire) begin
            busy       <= 1'b1;
            beats_left <= arlen;
         end else if (last_fire) begin
            busy <= 1'b0;
         end else if (r_fire) begin
            beats_left <= beats_left - 1'b1;
         end
      end
   end

   always_ff @(posedge aclk) begin
      cur_idx <= next_idx;
      if (ar_fire) begin
         id_q    <= arid;
         burst_q <= arburst;
      end
   end

   assign rvalid = beat_valid;
   assign rlast  = beat_valid & (beats_left == '0);
   assign rdata  = sram.rdata;
   assign rid    = id_q;
   assign rresp  = axi_sram_pkg::resp_okay;

   // a burst starts only once the previous data beat has drained
   a_ar_idle: assert property (
      @(posedge aclk) disable iff (!arst_n)
      ar_fire |-> !rvalid
   );

   // narrow transfers are not supported
   a_ar_size: assert property (
      @(posedge aclk) disable iff (!arst_n)
      ar_fire |-> arsize == axi_sram_pkg::size_dword
   );

   // held beat stays put until taken
   a_r_hold: assert property (
      @(posedge aclk) disable iff (!arst_n)
      rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rid) && $stable(rlast)
   );

endmodule

/* design/axi_sram_pkg.sv */
package axi_sram_pkg;

   // AXI bus geometry
   localparam int addr_w = 32;
   localparam int data_w = 64;
   localparam int strb_w = 8;
   localparam int id_w   = 4;
   localparam int len_w  = 8;

   // bank geometry, 8 KiB of 64-bit words
   localparam int bank_depth = 1024;
   localparam int index_w    = 10;

   // byte offset bits below the word index
   localparam int word_shift = 3;

   // burst type codes
   localparam logic [1:0] burst_fixed = 2'd0;
   localparam logic [1:0] burst_incr  = 2'd1;

   // response codes, only OKAY is ever returned
   localparam logic [1:0] resp_okay = 2'd0;

   // transfer size code for a full 64-bit beat
   localparam logic [2:0] size_dword = 3'd3;

   // write engine states
   localparam logic [1:0] wr_idle = 2'd0;
   localparam logic [1:0] wr_data = 2'd1;
   localparam logic [1:0] wr_resp = 2'd2;

endpackage

/* design/axi_sram_top.sv */
`timescale 1ns/1ps

module axi_sram_top (
   input  logic                            aclk,
   input  logic                            arst_n,

   input  logic [axi_sram_pkg::addr_w-1:0] araddr,
   input  logic [1:0]                      arburst,
   input  logic [3:0]                      arcache,
   input  logic [axi_sram_pkg::id_w-1:0]   arid,
   input  logic [axi_sram_pkg::len_w-1:0]  arlen,
   input  logic                            arlock,
   input  logic [2:0]                      arprot,
   output logic                            arready,
   input  logic [2:0]                      arsize,
   input  logic                            arvalid,

   output logic [axi_sram_pkg::data_w-1:0] rdata,
   output logic [axi_sram_pkg::id_w-1:0]   rid,
   output logic                            rlast,
   input  logic                            rready,
   output logic [1:0]                      rresp,
   output logic                            rvalid,

   input  logic [axi_sram_pkg::addr_w-1:0] awaddr,
   input  logic [1:0]                      awburst,
   input  logic [3:0]                      awcache,
   input  logic [axi_sram_pkg::id_w-1:0]   awid,
   input  logic [axi_sram_pkg::len_w-1:0]  awlen,
   input  logic                            awlock,
   input  logic [2:0]                      awprot,
   output logic                            awready,
   input  logic [2:0]                      awsize,
   input  logic                            awvalid,

   input  logic [axi_sram_pkg::data_w-1:0] wdata,
   input  logic [axi_sram_pkg::id_w-1:0]   wid,
   input  logic                            wlast,
   output logic                            wready,
   input  logic [axi_sram_pkg::strb_w-1:0] wstrb,
   input  logic                            wvalid,

   output logic [axi_sram_pkg::id_w-1:0]   bid,
   input  logic                            bready,
   output logic [1:0]                      bresp,
   output logic                            bvalid
);

   // cache, lock, prot and wid are accepted and ignored
   sram_if sram_bus ();

   axi_rd_channel u_rd (
      .aclk    (aclk),
      .arst_n  (arst_n),
      .araddr  (araddr),
      .arburst (arburst),
      .arlen   (arlen),
      .arid    (arid),
      .arsize  (arsize),
      .arvalid (arvalid),
      .arready (arready),
      .rdata   (rdata),
      .rid     (rid),
      .rresp   (rresp),
      .rlast   (rlast),
      .rvalid  (rvalid),
      .rready  (rready),
      .sram    (sram_bus.rd)
   );

   axi_wr_channel u_wr (
      .aclk    (aclk),
      .arst_n  (arst_n),
      .awaddr  (awaddr),
      .awburst (awburst),
      .awlen   (awlen),
      .awid    (awid),
      .awsize  (awsize),
      .awvalid (awvalid),
      .awready (awready),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .wlast   (wlast),
      .wvalid  (wvalid),
      .wready  (wready),
      .bid     (bid),
      .bresp   (bresp),
      .bvalid  (bvalid),
      .bready  (bready),
      .sram    (sram_bus.wr)
   );

   sram_bank u_bank (
      .aclk (aclk),
      .mem  (sram_bus.bank)
   );

endmodule

/* design/axi_wr_channel.sv */
`timescale 1ns/1ps

module axi_wr_channel (
   input  logic                            aclk,
   input  logic                            arst_n,

   input  logic [axi_sram_pkg::addr_w-1:0] awaddr,
   input  logic [1:0]                      awburst,
   input  logic [axi_sram_pkg::len_w-1:0]  awlen,
   input  logic [axi_sram_pkg::id_w-1:0]   awid,
   input  logic [2:0]                      awsize,
   input  logic                            awvalid,
   output logic                            awready,

   input  logic [axi_sram_pkg::data_w-1:0] wdata,
   input  logic [axi_sram_pkg::strb_w-1:0] wstrb,
   input  logic                            wlast,
   input  logic                            wvalid,
   output logic                            wready,

   output logic [axi_sram_pkg::id_w-1:0]   bid,
   output logic [1:0]                      bresp,
   output logic                            bvalid,
   input  logic                            bready,

   sram_if.wr                              sram
);

   logic [1:0]                       state;
   logic                             aw_fire;
   logic                             w_fire;
   logic                             b_fire;
   logic [axi_sram_pkg::index_w-1:0] idx_q;
   logic [axi_sram_pkg::index_w-1:0] beat_idx_q;
   logic [axi_sram_pkg::len_w-1:0]   beats_left;
   logic [axi_sram_pkg::id_w-1:0]    id_q;
   logic [1:0]                       burst_q;
   logic [axi_sram_pkg::data_w-1:0]  wdata_q;
   logic [axi_sram_pkg::strb_w-1:0]  wstrb_q;
   logic                             beat_pend;
   logic                             last_pend;
   logic                             bvalid_q;
   logic [axi_sram_pkg::strb_w-1:0]  beat_wen;

   assign aw_fire = awvalid & awready;
   assign w_fire  = wvalid & wready;
   assign b_fire  = bvalid & bready;

   assign awready = (state == axi_sram_pkg::wr_idle);
   assign wready  = (state == axi_sram_pkg::wr_data);

   always_ff @(posedge aclk or negedge arst_n) begin
      if (!arst_n) begin
         state      <= axi_sram_pkg::wr_idle;
         beats_left <= '0;
         beat_pend  <= 1'b0;
         last_pend  <= 1'b0;
         bvalid_q   <= 1'b0;
      end else begin
         beat_pend <= w_fire;
         last_pend <= w_fire & wlast;
         case (state)
            axi_sram_pkg::wr_idle: begin
               if (aw_fire) begin
                  state      <= axi_sram_pkg::wr_data;
                  beats_left <= awlen;
               end
            end
            axi_sram_pkg::wr_data: begin
               if (w_fire) begin
                  beats_left <= beats_left - 1'b1;
                  if (wlast) begin
                     state <= axi_sram_pkg::wr_resp;
                  end
               end
            end
            default: begin
               if (b_fire) begin
                  state <= axi_sram_pkg::wr_idle;
               end
            end
         endcase
         // response goes out the cycle after the last write lands
         if (beat_pend && last_pend) begin
            bvalid_q <= 1'b1;
         end else if (b_fire) begin
            bvalid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge aclk) begin
      if (aw_fire) begin
         idx_q   <= awaddr[axi_sram_pkg::word_shift +: axi_sram_pkg::index_w];
         id_q    <= awid;
         burst_q <= awburst;
      end else if (w_fire && burst_q != axi_sram_pkg::burst_fixed) begin
         idx_q <= idx_q + 1'b1;
      end
      // one-beat staging register in front of the bank
      if (w_fire) begin
         beat_idx_q <= idx_q;
         wdata_q    <= wdata;
         wstrb_q    <= wstrb;
      end
   end

   assign beat_wen = beat_pend ? wstrb_q : '0;

   assign sram.waddr = beat_idx_q;
   assign sram.wdata = wdata_q;
   assign sram.wen   = beat_wen;

   assign bvalid = bvalid_q;
   assign bid    = id_q;
   assign bresp  = axi_sram_pkg::resp_okay;

   // master must end the burst on beat awlen+1
   a_wlast_beat: assert property (
      @(posedge aclk) disable iff (!arst_n)
      w_fire |-> wlast == (beats_left == '0)
   );

   // no bank write while the engine is idle
   a_wen_idle: assert property (
      @(posedge aclk) disable iff (!arst_n)
      state == axi_sram_pkg::wr_idle |-> beat_wen == '0
   );

   a_aw_size: assert property (
      @(posedge aclk) disable iff (!arst_n)
      aw_fire |-> awsize == axi_sram_pkg::size_dword
   );

endmodule

/* design/sram_bank.sv */
`timescale 1ns/1ps

module sram_bank (
   input logic  aclk,
   sram_if.bank mem
);

   logic [axi_sram_pkg::data_w-1:0] mem_array [axi_sram_pkg::bank_depth];
   logic [axi_sram_pkg::data_w-1:0] rdata_q;

   // byte lanes written independently
   always_ff @(posedge aclk) begin
      for (int b = 0; b < axi_sram_pkg::strb_w; b++) begin
         if (mem.wen[b]) begin
            mem_array[mem.waddr][b*8 +: 8] <= mem.wdata[b*8 +: 8];
         end
      end
   end

   // registered read, old word on a same-cycle write
   always_ff @(posedge aclk) begin
      if (mem.ren) begin
         rdata_q <= mem_array[mem.raddr];
      end
   end

   // holds last read while ren is low
   assign mem.rdata = rdata_q;

endmodule

/* design/sram_if.sv */
`timescale 1ns/1ps

interface sram_if ();

   // read port, one cycle latency
   logic [axi_sram_pkg::index_w-1:0] raddr;
   logic                             ren;
   logic [axi_sram_pkg::data_w-1:0]  rdata;

   // write port, one enable per byte lane
   logic [axi_sram_pkg::index_w-1:0] waddr;
   logic [axi_sram_pkg::data_w-1:0]  wdata;
   logic [axi_sram_pkg::strb_w-1:0]  wen;

   modport bank (
      input  raddr,
      input  ren,
      input  waddr,
      input  wdata,
      input  wen,
      output rdata
   );

   modport rd (
      output raddr,
      output ren,
      input  rdata
   );

   modport wr (
      output waddr,
      output wdata,
      output wen
   );

endinterface

/* filelist.f */
design/axi_sram_pkg.sv
design/sram_if.sv
design/sram_bank.sv
design/axi_rd_channel.sv
design/axi_wr_channel.sv
design/axi_sram_top.sv
verif/tb_axi_sram.sv

/* verif/tb_axi_sram.sv */
`timescale 1ns/1ps

module tb_axi_sram;

   localparam logic [31:0] lfsr_seed = 32'h9fc9_de5d;
   localparam logic [31:0] lfsr_taps = 32'h8020_0003;
   // about four times the summed burst cycles of all tests
   localparam int timeout_cycles = 2000;

   logic        aclk;
   logic        arst_n;
   logic [31:0] araddr, awaddr;
   logic [1:0]  arburst, awburst;
   logic [3:0]  arcache, awcache, arid, awid, wid;
   logic [7:0]  arlen, awlen;
   logic        arlock, awlock;
   logic [2:0]  arprot, awprot, arsize, awsize;
   logic        arvalid, awvalid, arready, awready;
   logic [63:0] rdata, wdata;
   logic [3:0]  rid, bid;
   logic        rlast, rready, rvalid;
   logic [1:0]  rresp, bresp;
   logic        wlast, wready, wvalid;
   logic [7:0]  wstrb;
   logic        bready, bvalid;

   logic [31:0] lfsr = lfsr_seed;
   int          cycles = 0;
   bit          bp = 1'b0;
   logic [63:0] ref_mem [int];
   logic [63:0] rd_q [$];

   axi_sram_top u_dut (.*);

   always #2 aclk = ~aclk;

   always @(posedge aclk) begin
      cycles = cycles + 1;
      if (cycles >= timeout_cycles) begin
         $display("run did not finish within %0d cycles", timeout_cycles);
         $display("TEST FAILED");
         $fatal(1, "timeout");
      end
   end

   task automatic report_error(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1, "stopping at first error");
   endtask

   function automatic logic lfsr_bit();
      logic out;
      out = lfsr[0];
      lfsr = lfsr >> 1;
      if (out) begin
         lfsr = lfsr ^ lfsr_taps;
      end
      return out;
   endfunction

   function automatic logic [63:0] rand_data();
      logic [63:0] v;
      for (int i = 0; i < 64; i++) begin
         v[i] = lfsr_bit();
      end
      return v;
   endfunction

   function automatic logic [7:0] rand_strb();
      logic [7:0] v;
      for (int i = 0; i < 8; i++) begin
         v[i] = lfsr_bit();
      end
      return v;
   endfunction

   // byte offset dropped, index wraps inside the bank
   function automatic int word_index(input logic [31:0] addr);
      return int'(addr[axi_sram_pkg::word_shift +: axi_sram_pkg::index_w]);
   endfunction

   function automatic logic [63:0] merge_bytes(input logic [63:0] old_w,
                                               input logic [63:0] new_w,
                                               input logic [7:0] strb);
      logic [63:0] res;
      res = old_w;
      for (int b = 0; b < 8; b++) begin
         if (strb[b]) begin
            res[b*8 +: 8] = new_w[b*8 +: 8];
         end
      end
      return res;
   endfunction

   task automatic check_data(input string name, input logic [axi_sram_pkg::data_w-1:0] exp,
                             input logic [axi_sram_pkg::data_w-1:0] obs);
      if (obs !== exp) begin
         report_error($sformatf("Fail at %0t: %s expected %h observed %h",
                                $time, name, exp, obs));
      end
   endtask

   task automatic check_id(input string name, input logic [axi_sram_pkg::id_w-1:0] exp,
                           input logic [axi_sram_pkg::id_w-1:0] obs);
      if (obs !== exp) begin
         report_error($sformatf("Fail at %0t: %s expected %h observed %h",
                                $time, name, exp, obs));
      end
   endtask

   task automatic check_resp(input string name, input logic [1:0] obs);
      if (obs !== axi_sram_pkg::resp_okay) begin
         report_error($sformatf("Fail at %0t: %s expected %h observed %h",
                                $time, name, axi_sram_pkg::resp_okay, obs));
      end
   endtask

   task automatic axi_write(input logic [31:0] addr, input int len, input logic [1:0] burst,
                            input logic [3:0] id, input bit rand_strobes);
      int  idx;
      bit  fire;
      logic [63:0] data;
      logic [7:0]  strb;
      awaddr = addr;
      awlen = len[7:0];
      awburst = burst;
      awid = id;
      awvalid = 1'b1;
      do begin
         @(negedge aclk);
         fire = awready;
         @(posedge aclk);
         #0.5;
      end while (!fire);
      awvalid = 1'b0;
      idx = word_index(addr);
      for (int beat = 0; beat <= len; beat++) begin
         data = rand_data();
         strb = rand_strobes ? rand_strb() : 8'hff;
         wdata = data;
         wstrb = strb;
         wid = id;
         wlast = (beat == len);
         wvalid = 1'b1;
         do begin
            @(negedge aclk);
            fire = wready;
            @(posedge aclk);
            #0.5;
         end while (!fire);
         ref_mem[idx] = merge_bytes(ref_mem.exists(idx) ? ref_mem[idx] : '0, data, strb);
         if (burst != axi_sram_pkg::burst_fixed) begin
            idx = (idx + 1) % axi_sram_pkg::bank_depth;
         end
      end
      wvalid = 1'b0;
      wlast = 1'b0;
      do begin
         bready = bp ? lfsr_bit() : 1'b1;
         @(negedge aclk);
         fire = bvalid && bready;
         if (fire) begin
            check_id("bid", id, bid);
            check_resp("bresp", bresp);
         end
         @(posedge aclk);
         #0.5;
      end while (!fire);
      bready = 1'b0;
   endtask

   task automatic axi_read(input logic [31:0] addr, input int len, input logic [1:0] burst,
                           input logic [3:0] id);
      int  beat;
      bit  fire;
      bit  held;
      logic [63:0] held_data;
      rd_q.delete();
      araddr = addr;
      arlen = len[7:0];
      arburst = burst;
      arid = id;
      arvalid = 1'b1;
      do begin
         @(negedge aclk);
         fire = arready;
         @(posedge aclk);
         #0.5;
      end while (!fire);
      arvalid = 1'b0;
      beat = 0;
      held = 1'b0;
      held_data = '0;
      while (beat <= len) begin
         rready = bp ? lfsr_bit() : 1'b1;
         @(negedge aclk);
         if (held && (!rvalid || rdata !== held_data)) begin
            report_error("rdata or rvalid changed while the beat was held off");
         end
         held = rvalid && !rready;
         held_data = rdata;
         if (rvalid && rready) begin
            check_id("rid", id, rid);
            check_resp("rresp", rresp);
            if (rlast !== (beat == len)) begin
               report_error($sformatf("rlast wrong on beat %0d of %0d", beat + 1, len + 1));
            end
            rd_q.push_back(rdata);
            beat++;
         end
         @(posedge aclk);
         #0.5;
      end
      rready = 1'b0;
   endtask

   // read queue against the reference memory
   task automatic compare_burst(input logic [31:0] addr, input int len, input logic [1:0] burst);
      int idx;
      idx = word_index(addr);
      if (rd_q.size() != len + 1) begin
         report_error("read returned the wrong number of beats");
      end
      for (int beat = 0; beat <= len; beat++) begin
         check_data("rdata", ref_mem[idx], rd_q[beat]);
         if (burst != axi_sram_pkg::burst_fixed) begin
            idx = (idx + 1) % axi_sram_pkg::bank_depth;
         end
      end
   endtask

   task automatic single_beat();
      axi_write(32'h0000_0100, 0, axi_sram_pkg::burst_incr, 4'd3, 1'b0);
      axi_read(32'h0000_0100, 0, axi_sram_pkg::burst_incr, 4'd5);
      compare_burst(32'h0000_0100, 0, axi_sram_pkg::burst_incr);
   endtask

   task automatic incr_burst();
      axi_write(32'h0000_0400, 15, axi_sram_pkg::burst_incr, 4'd7, 1'b0);
      axi_read(32'h0000_0400, 15, axi_sram_pkg::burst_incr, 4'd2);
      compare_burst(32'h0000_0400, 15, axi_sram_pkg::burst_incr);
   endtask

   task automatic partial_strobes();
      axi_write(32'h0000_0800, 0, axi_sram_pkg::burst_incr, 4'd1, 1'b0);
      axi_write(32'h0000_0800, 0, axi_sram_pkg::burst_incr, 4'd6, 1'b1);
      axi_read(32'h0000_0800, 0, axi_sram_pkg::burst_incr, 4'd8);
      compare_burst(32'h0000_0800, 0, axi_sram_pkg::burst_incr);
   endtask

   // only the last beat survives at a fixed address
   task automatic fixed_burst();
      axi_write(32'h0000_0a00, 3, axi_sram_pkg::burst_fixed, 4'd11, 1'b0);
      axi_read(32'h0000_0a00, 3, axi_sram_pkg::burst_fixed, 4'd12);
      compare_burst(32'h0000_0a00, 3, axi_sram_pkg::burst_fixed);
   endtask

   task automatic back_pressure();
      logic [63:0] r;
      logic [31:0] addr;
      r = rand_data();
      addr = 32'h0000_1000 + {21'd0, r[7:0], 3'd0};
      bp = 1'b1;
      axi_write(addr, 31, axi_sram_pkg::burst_incr, 4'd13, 1'b0);
      axi_read(addr, 31, axi_sram_pkg::burst_incr, 4'd14);
      compare_burst(addr, 31, axi_sram_pkg::burst_incr);
      bp = 1'b0;
   endtask

   task automatic parallel_rw();
      fork
         axi_write(32'h0000_1800, 7, axi_sram_pkg::burst_incr, 4'd9, 1'b0);
         axi_read(32'h0000_0400, 15, axi_sram_pkg::burst_incr, 4'd4);
      join
      compare_burst(32'h0000_0400, 15, axi_sram_pkg::burst_incr);
      axi_read(32'h0000_1800, 7, axi_sram_pkg::burst_incr, 4'd10);
      compare_burst(32'h0000_1800, 7, axi_sram_pkg::burst_incr);
   endtask

   initial begin
      aclk = 1'b0;
      arst_n = 1'b0;
      araddr = '0;
      arburst = axi_sram_pkg::burst_incr;
      arcache = '0;
      arid = '0;
      arlen = '0;
      arlock = 1'b0;
      arprot = '0;
      arsize = axi_sram_pkg::size_dword;
      arvalid = 1'b0;
      rready = 1'b0;
      awaddr = '0;
      awburst = axi_sram_pkg::burst_incr;
      awcache = '0;
      awid = '0;
      awlen = '0;
      awlock = 1'b0;
      awprot = '0;
      awsize = axi_sram_pkg::size_dword;
      awvalid = 1'b0;
      wdata = '0;
      wid = '0;
      wlast = 1'b0;
      wstrb = '0;
      wvalid = 1'b0;
      bready = 1'b0;
      repeat (16) @(posedge aclk);
      #0.5;
      arst_n = 1'b1;
      single_beat();
      incr_burst();
      partial_strobes();
      fixed_burst();
      back_pressure();
      parallel_rw();
      $display("TEST PASSED");
      $finish;
   end

endmodule
